//--- hw/uart_rx_pkg.sv
// shared widths, state and parity encodings and config struct for the uart rx engine; import it
package uart_rx_pkg;

	// ==================================================
	// widths
	// ==================================================

	// widest data word, 10 bits
	localparam int data_w = 10;

	// ==================================================
	// encodings
	// ==================================================

	// one-hot receiver state
	typedef enum logic [5:0] {
		st_idle   = 6'b000001,
		st_start  = 6'b000010,
		st_data   = 6'b000100,
		st_parity = 6'b001000,
		st_stop   = 6'b010000,
		st_end    = 6'b100000
	} rx_state_t;

	// expected parity bit
	// even: xor of data, odd: its inverse
	typedef enum logic [1:0] {
		par_even = 2'd0,
		par_odd  = 2'd1,
		par_zero = 2'd2,
		par_one  = 2'd3
	} parity_mode_t;

	// ==================================================
	// frame config
	// ==================================================

	typedef struct packed {
		// 5 to 10 data bits
		logic [3:0]   data_bits;
		logic         parity_en;
		parity_mode_t parity_mode;
		// 1 to 3 stop bits
		logic [1:0]   stop_bits;
		// keep frames with errors
		logic         error_ignore;
	} rx_cfg_t;

endpackage

//--- hw/rx_tick_if.sv
// bit-timing strobes from the rx bit timer to the frame FSM and the frame checker
`timescale 1ns/10ps

interface rx_tick_if;

	// frame in progress, timer counts
	logic run;
	// mid-bit sample point, one clock
	logic sample;
	// sample delayed by one clock
	logic sample_d;
	// last clock of the bit period
	logic bit_end;

	modport timer
	(
		input  run,
		output sample,
		output sample_d,
		output bit_end
	);

	modport fsm
	(
		output run,
		input  sample_d,
		input  bit_end
	);

	modport check
	(
		input  sample,
		input  bit_end
	);

endinterface

//--- hw/rx_frame_if.sv
// frame progress from the rx frame FSM to the frame checker, error flag back
`timescale 1ns/10ps

interface rx_frame_if;
	import uart_rx_pkg::*;

	rx_state_t  state;
	// current data bit, counts from 1
	logic [3:0] bit_idx;
	// entry to start state
	logic       frame_start;
	// sample_d of last stop bit
	logic       frame_done;
	// parity or stop error held for this frame
	logic       frame_error;

	modport fsm
	(
		output state,
		output bit_idx,
		output frame_start,
		output frame_done
	);

	modport check
	(
		input  state,
		input  bit_idx,
		input  frame_start,
		input  frame_done,
		output frame_error
	);

endinterface

//--- hw/rx_bit_timer.sv
// oversampled bit timing for the uart rx engine; instantiated by the rx top level
`timescale 1ns/10ps

module rx_bit_timer
#(
	parameter int clkdiv_w = 12,
	parameter int os_w     = 4
)
(
	input  logic                pe_clk,
	input  logic                pe_rstn,
	input  logic [clkdiv_w-1:0] r_clkdiv,
	input  logic [os_w-1:0]     r_oversampling,
	rx_tick_if.timer            tick
);

	// ==================================================
	// counters
	// one bit = r_clkdiv x r_oversampling clocks
	// ==================================================

	logic [clkdiv_w-1:0] div_cnt;
	logic [os_w-1:0]     os_cnt;
	logic                div_end;
	logic                os_end;
	logic                sample_pt;
	logic                sample_q;

	assign div_end = (div_cnt == (r_clkdiv - clkdiv_w'(1)));
	assign os_end  = (os_cnt == (r_oversampling - os_w'(1)));

	// divider, wraps every r_clkdiv clocks
	always_ff @(posedge pe_clk or negedge pe_rstn)
	begin
		if (!pe_rstn)
			div_cnt <= '0;
		else if (!tick.run || div_end)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + clkdiv_w'(1);
	end

	// oversampling point counter
	// steps once per divider wrap
	always_ff @(posedge pe_clk or negedge pe_rstn)
	begin
		if (!pe_rstn)
			os_cnt <= '0;
		else if (!tick.run)
			os_cnt <= '0;
		else if (div_end)
		begin
			if (os_end)
				os_cnt <= '0;
			else
				os_cnt <= os_cnt + os_w'(1);
		end
	end

	// ==================================================
	// strobes
	// ==================================================

	// middle oversampling point, first divider clock only
	assign sample_pt = (os_cnt == (r_oversampling >> 1)) && (div_cnt == '0);

	// one clock later, sampled value already stored
	always_ff @(posedge pe_clk or negedge pe_rstn)
	begin
		if (!pe_rstn)
			sample_q <= 1'b0;
		else
			sample_q <= sample_pt;
	end

	assign tick.sample   = sample_pt;
	assign tick.sample_d = sample_q;
	// last divider clock of last oversampling point
	assign tick.bit_end  = os_end && div_end;

endmodule

//--- hw/rx_frame_fsm.sv
// uart rx frame FSM with start detection, noise filter and bit counters; used by the rx top
`timescale 1ns/10ps

module rx_frame_fsm
(
	input  logic                 pe_clk,
	input  logic                 pe_rstn,
	input  logic                 uart_rx,
	input  logic                 pe_rx_enable,
	input  logic                 pe_rx_logic_clr,
	input  uart_rx_pkg::rx_cfg_t cfg,
	rx_tick_if.fsm               tick,
	rx_frame_if.fsm              frame,
	output logic                 pe_rx_end,
	output logic                 int_status_rx_noise_detect
);
	import uart_rx_pkg::*;

	rx_state_t  state;
	rx_state_t  next_state;
	logic       line_idle;
	logic       line_idle_q;
	logic       line_start;
	logic       line_start_q;
	logic       rx_fall;
	logic       rx_rise;
	logic       start_half;
	logic       noise_q;
	logic [3:0] bit_idx;
	logic [1:0] stop_cnt;
	logic       data_last;
	logic       stop_done;
	logic       end_q;

	// ==================================================
	// line edges
	// ==================================================

	// falling edge only counts while idle and enabled
	assign line_idle  = uart_rx && pe_rx_enable && (state == st_idle);
	// rising edge only counts inside the start bit
	assign line_start = uart_rx && pe_rx_enable && (state == st_start);

	always_ff @(posedge pe_clk or negedge pe_rstn)
	begin
		if (!pe_rstn)
		begin
			line_idle_q  <= 1'b0;
			line_start_q <= 1'b0;
		end
		else
		begin
			line_idle_q  <= line_idle;
			line_start_q <= line_start;
		end
	end

	assign rx_fall = line_idle_q && !line_idle;
	assign rx_rise = line_start && !line_start_q;

	// noise window open until first sample_d of the start bit
	always_ff @(posedge pe_clk or negedge pe_rstn)
	begin
		if (!pe_rstn)
			start_half <= 1'b1;
		else if (state != st_start)
			start_half <= 1'b1;
		else if (tick.sample_d)
			start_half <= 1'b0;
	end

	// start bit went high too early, drop it
	always_ff @(posedge pe_clk or negedge pe_rstn)
	begin
		if (!pe_rstn)
			noise_q <= 1'b0;
		else
			noise_q <= (state == st_start) && start_half && rx_rise;
	end

	// ==================================================
	// state machine
	// ==================================================

	always_ff @(posedge pe_clk or negedge pe_rstn)
	begin
		if (!pe_rstn)
			state <= st_idle;
		else
			state <= next_state;
	end

	always_comb
	begin
		next_state = state;
		// logic clear aborts any frame
		if ((state != st_idle) && pe_rx_logic_clr)
			next_state = st_idle;
		else
		begin
			case (state)
				st_idle:
					if (rx_fall)
						next_state = st_start;
				st_start:
					if (noise_q)
						next_state = st_idle;
					else if (tick.bit_end)
						next_state = st_data;
				st_data:
					if (data_last)
						next_state = cfg.parity_en ? st_parity : st_stop;
				st_parity:
					if (tick.bit_end)
						next_state = st_stop;
				st_stop:
					if (stop_done)
						next_state = st_end;
				st_end:
					if (end_q)
						next_state = st_idle;
				default:
					next_state = st_idle;
			endcase
		end
	end

	// ==================================================
	// bit counters
	// ==================================================

	// preset to 1 during start, steps at each data bit end
	always_ff @(posedge pe_clk or negedge pe_rstn)
	begin
		if (!pe_rstn)
			bit_idx <= 4'd0;
		else if (state == st_start)
			bit_idx <= 4'd1;
		else if ((state == st_data) && tick.bit_end)
			bit_idx <= bit_idx + 4'd1;
	end

	assign data_last = (state == st_data) && tick.bit_end && (bit_idx == cfg.data_bits);

	// first stop bit counts as 1
	always_ff @(posedge pe_clk or negedge pe_rstn)
	begin
		if (!pe_rstn)
			stop_cnt <= 2'd0;
		else if ((next_state == st_stop) && (state != st_stop))
			stop_cnt <= 2'd1;
		else if ((state == st_stop) && tick.bit_end)
			stop_cnt <= stop_cnt + 2'd1;
	end

	// frame ends mid last stop bit, ready for the next start edge
	assign stop_done = (state == st_stop) && tick.sample_d && (stop_cnt == cfg.stop_bits);

	// end pulse, one clock
	always_ff @(posedge pe_clk or negedge pe_rstn)
	begin
		if (!pe_rstn)
			end_q <= 1'b0;
		else
			end_q <= (state == st_end) && !end_q;
	end

	// ==================================================
	// outputs
	// ==================================================

	assign tick.run = (state == st_start) || (state == st_data) ||
		(state == st_parity) || (state == st_stop);

	assign frame.state       = state;
	assign frame.bit_idx     = bit_idx;
	assign frame.frame_start = rx_fall;
	assign frame.frame_done  = stop_done && !pe_rx_logic_clr;

	assign pe_rx_end                  = end_q;
	assign int_status_rx_noise_detect = noise_q;

endmodule

//--- hw/rx_frame_checker.sv
// uart rx data capture, parity and stop checks and fifo write; used by the rx top level
`timescale 1ns/10ps

module rx_frame_checker
(
	input  logic                          pe_clk,
	input  logic                          pe_rstn,
	input  logic                          uart_rx,
	input  uart_rx_pkg::rx_cfg_t          cfg,
	rx_tick_if.check                      tick,
	rx_frame_if.check                     frame,
	output logic                          fifo_we,
	output logic [uart_rx_pkg::data_w-1:0] fifo_data,
	output logic                          int_status_rx_parity_error,
	output logic                          int_status_rx_stop_error,
	output logic                          int_status_rx_stop_detect
);
	import uart_rx_pkg::*;

	logic [data_w-1:0] rx_data;
	logic              parity_load;
	logic              exp_parity;
	logic              parity_err;
	logic              stop_err;
	logic              err_held;

	// ==================================================
	// data capture
	// ==================================================

	// cleared per frame, unused upper bits stay 0
	always_ff @(posedge pe_clk)
	begin
		if (frame.frame_start)
			rx_data <= '0;
		else if (tick.sample && (frame.state == st_data))
			rx_data[frame.bit_idx - 4'd1] <= uart_rx;
	end

	// ==================================================
	// parity
	// ==================================================

	// data to parity transition
	assign parity_load = (frame.state == st_data) && tick.bit_end && cfg.parity_en &&
		(frame.bit_idx == cfg.data_bits);

	always_ff @(posedge pe_clk or negedge pe_rstn)
	begin
		if (!pe_rstn)
			exp_parity <= 1'b0;
		else if (parity_load)
		begin
			case (cfg.parity_mode)
				par_even: exp_parity <= ^rx_data;
				par_odd:  exp_parity <= ~(^rx_data);
				par_zero: exp_parity <= 1'b0;
				default:  exp_parity <= 1'b1;
			endcase
		end
	end

	// ==================================================
	// error flags
	// ==================================================

	// level until parity state left
	always_ff @(posedge pe_clk or negedge pe_rstn)
	begin
		if (!pe_rstn)
			parity_err <= 1'b0;
		else if (frame.state != st_parity)
			parity_err <= 1'b0;
		else if (tick.sample && (uart_rx != exp_parity))
			parity_err <= 1'b1;
	end

	// any low stop bit, level until stop state left
	always_ff @(posedge pe_clk or negedge pe_rstn)
	begin
		if (!pe_rstn)
			stop_err <= 1'b0;
		else if (frame.state != st_stop)
			stop_err <= 1'b0;
		else if (tick.sample && !uart_rx)
			stop_err <= 1'b1;
	end

	// parity error kept through the stop bits
	always_ff @(posedge pe_clk or negedge pe_rstn)
	begin
		if (!pe_rstn)
			err_held <= 1'b0;
		else if (frame.frame_start)
			err_held <= 1'b0;
		else if (parity_err)
			err_held <= 1'b1;
	end

	assign frame.frame_error = err_held || parity_err || stop_err;

	// ==================================================
	// fifo write
	// ==================================================

	// bad frame dropped unless error_ignore
	always_ff @(posedge pe_clk or negedge pe_rstn)
	begin
		if (!pe_rstn)
		begin
			fifo_we   <= 1'b0;
			fifo_data <= '0;
		end
		else if (frame.frame_done && (!frame.frame_error || cfg.error_ignore))
		begin
			fifo_we   <= 1'b1;
			fifo_data <= rx_data;
		end
		else
		begin
			fifo_we   <= 1'b0;
			fifo_data <= '0;
		end
	end

	assign int_status_rx_parity_error = parity_err;
	assign int_status_rx_stop_error   = stop_err;
	// word accepted
	assign int_status_rx_stop_detect  = fifo_we;

endmodule

//--- hw/uart_rx_top.sv
// uart rx protocol engine top level with plain config ports; instantiate it in the system or bench
`timescale 1ns/10ps

module uart_rx_top
#(
	parameter int clkdiv_w = 12,
	parameter int os_w     = 4
)
(
	input  logic                           pe_clk,
	input  logic                           pe_rstn,
	// serial line
	input  logic                           uart_rx,
	// config
	input  logic [clkdiv_w-1:0]            r_clkdiv,
	input  logic [os_w-1:0]                r_oversampling,
	input  logic [3:0]                     r_data_bit,
	input  logic                           r_parity_en,
	input  logic [1:0]                     r_parity,
	input  logic [1:0]                     r_stop_bit,
	input  logic                           r_error_ignore,
	// control
	input  logic                           pe_rx_enable,
	input  logic                           pe_rx_logic_clr,
	// toward rx fifo
	output logic                           fifo_we,
	output logic [uart_rx_pkg::data_w-1:0] fifo_data,
	output logic                           pe_rx_end,
	// interrupt status
	output logic                           int_status_rx_parity_error,
	output logic                           int_status_rx_stop_error,
	output logic                           int_status_rx_stop_detect,
	output logic                           int_status_rx_noise_detect
);
	import uart_rx_pkg::*;

	rx_cfg_t cfg;

	// ==================================================
	// config packing
	// ==================================================

	assign cfg.data_bits    = r_data_bit;
	assign cfg.parity_en    = r_parity_en;
	assign cfg.parity_mode  = parity_mode_t'(r_parity);
	assign cfg.stop_bits    = r_stop_bit;
	assign cfg.error_ignore = r_error_ignore;

	// ==================================================
	// timer -> fsm -> checker
	// ==================================================

	rx_tick_if  tick ();
	rx_frame_if frame ();

	rx_bit_timer
	#(
		.clkdiv_w       (clkdiv_w),
		.os_w           (os_w)
	)
	u_timer
	(
		.pe_clk         (pe_clk),
		.pe_rstn        (pe_rstn),
		.r_clkdiv       (r_clkdiv),
		.r_oversampling (r_oversampling),
		.tick           (tick)
	);

	rx_frame_fsm u_fsm
	(
		.pe_clk                     (pe_clk),
		.pe_rstn                    (pe_rstn),
		.uart_rx                    (uart_rx),
		.pe_rx_enable               (pe_rx_enable),
		.pe_rx_logic_clr            (pe_rx_logic_clr),
		.cfg                        (cfg),
		.tick                       (tick),
		.frame                      (frame),
		.pe_rx_end                  (pe_rx_end),
		.int_status_rx_noise_detect (int_status_rx_noise_detect)
	);

	rx_frame_checker u_checker
	(
		.pe_clk                     (pe_clk),
		.pe_rstn                    (pe_rstn),
		.uart_rx                    (uart_rx),
		.cfg                        (cfg),
		.tick                       (tick),
		.frame                      (frame),
		.fifo_we                    (fifo_we),
		.fifo_data                  (fifo_data),
		.int_status_rx_parity_error (int_status_rx_parity_error),
		.int_status_rx_stop_error   (int_status_rx_stop_error),
		.int_status_rx_stop_detect  (int_status_rx_stop_detect)
	);

endmodule

//--- dv/uart_rx_sva.sv
// concurrent checks on the uart rx output pulses; bound into the rx top level by the testbench
`timescale 1ns/10ps

module uart_rx_sva
(
	input logic                           pe_clk,
	input logic                           pe_rstn,
	input logic                           fifo_we,
	input logic [uart_rx_pkg::data_w-1:0] fifo_data,
	input logic                           pe_rx_end,
	input logic                           int_status_rx_parity_error,
	input logic                           int_status_rx_stop_error,
	input logic                           int_status_rx_stop_detect,
	input logic                           int_status_rx_noise_detect
);

	// ==================================================
	// pulse widths
	// ==================================================

	// one write per frame, single clock
	a_we_pulse: assert property (@(posedge pe_clk) disable iff (!pe_rstn)
		fifo_we |=> !fifo_we)
		else $error("fifo_we stayed high for more than one clock");

	// end of frame strobe, one clock after the write
	a_end_after_we: assert property (@(posedge pe_clk) disable iff (!pe_rstn)
		fifo_we |=> pe_rx_end)
		else $error("pe_rx_end did not follow fifo_we by one clock");

	// and low again the clock after
	a_end_pulse: assert property (@(posedge pe_clk) disable iff (!pe_rstn)
		$past(fifo_we) |=> !pe_rx_end)
		else $error("pe_rx_end stayed high for more than one clock");

	// ==================================================
	// pulse relations
	// ==================================================

	// stop detect mirrors the write
	a_stop_detect: assert property (@(posedge pe_clk) disable iff (!pe_rstn)
		int_status_rx_stop_detect == fifo_we)
		else $error("int_status_rx_stop_detect differs from fifo_we");

	// dropped start bit never produces a word
	a_noise_no_we: assert property (@(posedge pe_clk) disable iff (!pe_rstn)
		!(int_status_rx_noise_detect && fifo_we))
		else $error("noise detect and fifo write in the same clock");

	// all outputs quiet while reset held
	a_reset_quiet: assert property (@(posedge pe_clk)
		(!pe_rstn && !$past(pe_rstn)) |-> !(fifo_we || pe_rx_end || (|fifo_data) ||
		int_status_rx_parity_error || int_status_rx_stop_error ||
		int_status_rx_stop_detect || int_status_rx_noise_detect))
		else $error("an output is high during reset");

endmodule

//--- dv/uart_rx_tb.sv
// testbench for the uart rx engine; sends serial frames and checks fifo writes and status flags
`timescale 1ns/10ps

module uart_rx_tb;
	import uart_rx_pkg::*;

	localparam int clkdiv_w   = 12;
	localparam int os_w       = 4;
	// 3 x 8 clocks per bit
	localparam int bit_clks   = 24;
	// ~45 frames of up to 14 bits, plus margin
	localparam int max_cycles = 40000;

	logic                pe_clk;
	logic                pe_rstn;
	logic                uart_rx;
	logic [clkdiv_w-1:0] r_clkdiv;
	logic [os_w-1:0]     r_oversampling;
	logic [3:0]          r_data_bit;
	logic                r_parity_en;
	logic [1:0]          r_parity;
	logic [1:0]          r_stop_bit;
	logic                r_error_ignore;
	logic                pe_rx_enable;
	logic                pe_rx_logic_clr;
	logic                fifo_we;
	logic [data_w-1:0]   fifo_data;
	logic                pe_rx_end;
	logic                int_status_rx_parity_error;
	logic                int_status_rx_stop_error;
	logic                int_status_rx_stop_detect;
	logic                int_status_rx_noise_detect;

	// expected words, filled by stimulus, consumed by the write monitor
	logic [data_w-1:0] exp_mem [0:63];
	logic [5:0]        wr_ptr = '0;
	logic [5:0]        rd_ptr = '0;

	int seed        = 17;
	int data_errs   = 0;
	int write_errs  = 0;
	int status_errs = 0;
	int writes_seen = 0;
	int parity_hits = 0;
	int stop_hits   = 0;
	int noise_hits  = 0;
	int cycles      = 0;

	uart_rx_top
	#(
		.clkdiv_w (clkdiv_w),
		.os_w     (os_w)
	)
	UUT
	(
		.pe_clk                     (pe_clk),
		.pe_rstn                    (pe_rstn),
		.uart_rx                    (uart_rx),
		.r_clkdiv                   (r_clkdiv),
		.r_oversampling             (r_oversampling),
		.r_data_bit                 (r_data_bit),
		.r_parity_en                (r_parity_en),
		.r_parity                   (r_parity),
		.r_stop_bit                 (r_stop_bit),
		.r_error_ignore             (r_error_ignore),
		.pe_rx_enable               (pe_rx_enable),
		.pe_rx_logic_clr            (pe_rx_logic_clr),
		.fifo_we                    (fifo_we),
		.fifo_data                  (fifo_data),
		.pe_rx_end                  (pe_rx_end),
		.int_status_rx_parity_error (int_status_rx_parity_error),
		.int_status_rx_stop_error   (int_status_rx_stop_error),
		.int_status_rx_stop_detect  (int_status_rx_stop_detect),
		.int_status_rx_noise_detect (int_status_rx_noise_detect)
	);

	bind uart_rx_top uart_rx_sva u_sva
	(
		.pe_clk                     (pe_clk),
		.pe_rstn                    (pe_rstn),
		.fifo_we                    (fifo_we),
		.fifo_data                  (fifo_data),
		.pe_rx_end                  (pe_rx_end),
		.int_status_rx_parity_error (int_status_rx_parity_error),
		.int_status_rx_stop_error   (int_status_rx_stop_error),
		.int_status_rx_stop_detect  (int_status_rx_stop_detect),
		.int_status_rx_noise_detect (int_status_rx_noise_detect)
	);

	// 100 ns clock
	initial
	begin
		pe_clk = 1'b0;
		forever #50 pe_clk = ~pe_clk;
	end

	// ==================================================
	// expected values
	// ==================================================

	// bits above the data length read zero
	function automatic logic [data_w-1:0] keep_low_bits(input logic [data_w-1:0] data,
		input int nbits);
		logic [data_w-1:0] word;
		word = '0;
		for (int i = 0; i < nbits; i++)
			word[i] = data[i];
		return word;
	endfunction

	// even means the bit equals the xor of the data
	function automatic logic parity_bit(input logic [data_w-1:0] data, input parity_mode_t mode);
		case (mode)
			par_even: return ^data;
			par_odd:  return ~(^data);
			par_zero: return 1'b0;
			default:  return 1'b1;
		endcase
	endfunction

	task automatic expect_word(input logic [data_w-1:0] word);
		exp_mem[wr_ptr] = word;
		wr_ptr = wr_ptr + 6'd1;
	endtask

	task automatic check_flag(input string name, input logic seen, input logic want);
		assert (seen == want)
		else
		begin
			$display("[FAIL] %0t %s got %0b expected %0b", $time, name, seen, want);
			status_errs++;
		end
	endtask

	// ==================================================
	// line driver
	// ==================================================

	// entered and left on a rising edge
	task automatic send_bit(input logic b);
		uart_rx <= b;
		repeat (bit_clks) @(posedge pe_clk);
	endtask

	task automatic send_idle(input int nbits);
		for (int i = 0; i < nbits; i++)
			send_bit(1'b1);
	endtask

	// lsb first, first stop bit may be forced low
	task automatic send_frame(input logic [data_w-1:0] data, input int nbits, input logic par_en,
		input logic par, input int nstop, input logic first_stop);
		send_bit(1'b0);
		for (int i = 0; i < nbits; i++)
			send_bit(data[i]);
		if (par_en)
			send_bit(par);
		send_bit(first_stop);
		for (int i = 1; i < nstop; i++)
			send_bit(1'b1);
	endtask

	task automatic set_format(input int nbits, input logic par_en, input parity_mode_t mode,
		input int nstop, input logic ignore);
		r_data_bit     <= 4'(nbits);
		r_parity_en    <= par_en;
		r_parity       <= mode;
		r_stop_bit     <= 2'(nstop);
		r_error_ignore <= ignore;
		@(posedge pe_clk);
	endtask

	task automatic random_word(input int nbits, output logic [data_w-1:0] word);
		int rnd;
		rnd  = $random(seed);
		word = keep_low_bits(rnd[data_w-1:0], nbits);
	endtask

	// ==================================================
	// test sequences
	// ==================================================

	// twenty 8N1 frames, no gap
	task automatic run_back_to_back();
		logic [data_w-1:0] word;
		set_format(8, 1'b0, par_even, 1, 1'b0);
		for (int n = 0; n < 20; n++)
		begin
			random_word(8, word);
			expect_word(word);
			send_frame(word, 8, 1'b0, 1'b0, 1, 1'b1);
		end
		send_idle(1);
	endtask

	// good, bad dropped, bad kept, per mode
	task automatic run_parity_modes();
		logic [data_w-1:0] word;
		parity_mode_t      mode;
		logic              good;
		int                hits;
		for (int m = 0; m < 4; m++)
		begin
			mode = parity_mode_t'(m[1:0]);
			set_format(7, 1'b1, mode, 1, 1'b0);
			random_word(7, word);
			good = parity_bit(word, mode);
			hits = parity_hits;
			expect_word(word);
			send_frame(word, 7, 1'b1, good, 1, 1'b1);
			check_flag("int_status_rx_parity_error", parity_hits != hits, 1'b0);
			hits = parity_hits;
			send_frame(word, 7, 1'b1, ~good, 1, 1'b1);
			check_flag("int_status_rx_parity_error", parity_hits != hits, 1'b1);
			set_format(7, 1'b1, mode, 1, 1'b1);
			hits = parity_hits;
			expect_word(word);
			send_frame(word, 7, 1'b1, ~good, 1, 1'b1);
			check_flag("int_status_rx_parity_error", parity_hits != hits, 1'b1);
		end
	endtask

	task automatic run_stop_checks();
		logic [data_w-1:0] word;
		int                hits;
		// low stop bit, frame dropped
		set_format(8, 1'b0, par_even, 1, 1'b0);
		random_word(8, word);
		hits = stop_hits;
		send_frame(word, 8, 1'b0, 1'b0, 1, 1'b0);
		send_idle(1);
		check_flag("int_status_rx_stop_error", stop_hits != hits, 1'b1);
		// 10 data bits, 2 stop bits
		set_format(10, 1'b0, par_even, 2, 1'b0);
		random_word(10, word);
		hits = stop_hits;
		expect_word(word);
		send_frame(word, 10, 1'b0, 1'b0, 2, 1'b1);
		check_flag("int_status_rx_stop_error", stop_hits != hits, 1'b0);
	endtask

	// quarter-bit glitch, then a normal frame
	task automatic run_noise();
		logic [data_w-1:0] word;
		int                hits;
		set_format(8, 1'b0, par_even, 1, 1'b0);
		hits = noise_hits;
		uart_rx <= 1'b0;
		repeat (bit_clks / 4) @(posedge pe_clk);
		send_idle(1);
		check_flag("int_status_rx_noise_detect", noise_hits != hits, 1'b1);
		random_word(8, word);
		expect_word(word);
		send_frame(word, 8, 1'b0, 1'b0, 1, 1'b1);
	endtask

	task automatic run_clear_and_enable();
		logic [data_w-1:0] word;
		random_word(8, word);
		send_bit(1'b0);
		for (int i = 0; i < 3; i++)
			send_bit(word[i]);
		// cancel in data bit 4, receiver held off for the rest
		pe_rx_logic_clr <= 1'b1;
		pe_rx_enable    <= 1'b0;
		@(posedge pe_clk);
		pe_rx_logic_clr <= 1'b0;
		for (int i = 3; i < 8; i++)
			send_bit(word[i]);
		send_bit(1'b1);
		// whole frame while disabled
		send_frame(word, 8, 1'b0, 1'b0, 1, 1'b1);
		send_idle(1);
		// re-enable with the line high
		pe_rx_enable <= 1'b1;
		@(posedge pe_clk);
		send_idle(1);
		expect_word(word);
		send_frame(word, 8, 1'b0, 1'b0, 1, 1'b1);
	endtask

	// ==================================================
	// monitors
	// ==================================================

	// outputs sampled mid cycle
	always @(negedge pe_clk)
	begin
		if (pe_rstn && fifo_we)
		begin
			writes_seen++;
			if (rd_ptr == wr_ptr)
			begin
				$display("%0t: fifo write of %h while no frame was expected", $time, fifo_data);
				write_errs++;
			end
			else
			begin
				assert (fifo_data == exp_mem[rd_ptr])
				else
				begin
					$display("[FAIL] %0t fifo_data got %h expected %h", $time, fifo_data,
						exp_mem[rd_ptr]);
					data_errs++;
				end
				rd_ptr = rd_ptr + 6'd1;
			end
		end
	end

	// clocks each status flag was seen high
	always @(negedge pe_clk)
	begin
		if (int_status_rx_parity_error)
			parity_hits++;
		if (int_status_rx_stop_error)
			stop_hits++;
		if (int_status_rx_noise_detect)
			noise_hits++;
	end

	task automatic report_end(input logic timed_out);
		logic [5:0] pending;
		pending = wr_ptr - rd_ptr;
		assert (pending == 6'd0)
		else
			$display("%0d expected fifo writes never arrived", pending);
		$display("errors: data %0d, write %0d, status %0d, missing %0d; writes seen %0d",
			data_errs, write_errs, status_errs, pending, writes_seen);
		if (!timed_out && (data_errs == 0) && (write_errs == 0) && (status_errs == 0) &&
			(pending == 6'd0))
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	endtask

	// run limit
	always @(posedge pe_clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles)
		begin
			$display("timeout: run did not finish within %0d clock cycles", max_cycles);
			report_end(1'b1);
		end
	end

	// ==================================================
	// main sequence
	// ==================================================

	initial
	begin
		pe_rstn         <= 1'b0;
		uart_rx         <= 1'b1;
		r_clkdiv        <= 12'd3;
		r_oversampling  <= 4'd8;
		r_data_bit      <= 4'd8;
		r_parity_en     <= 1'b0;
		r_parity        <= par_even;
		r_stop_bit      <= 2'd1;
		r_error_ignore  <= 1'b0;
		pe_rx_enable    <= 1'b1;
		pe_rx_logic_clr <= 1'b0;
		repeat (16) @(posedge pe_clk);
		pe_rstn <= 1'b1;
		repeat (2) @(posedge pe_clk);
		run_back_to_back();
		run_parity_modes();
		run_stop_checks();
		run_noise();
		run_clear_and_enable();
		// last write lands mid stop bit
		while (rd_ptr != wr_ptr)
			@(posedge pe_clk);
		report_end(1'b0);
	end

endmodule

//--- verilog.f
hw/uart_rx_pkg.sv
hw/rx_tick_if.sv
hw/rx_frame_if.sv
hw/rx_bit_timer.sv
hw/rx_frame_fsm.sv
hw/rx_frame_checker.sv
hw/uart_rx_top.sv
dv/uart_rx_sva.sv
dv/uart_rx_tb.sv

//--- run.sh
#!/usr/bin/env bash
# builds the uart rx testbench with verilator, runs it and checks the result
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module uart_rx_tb -f verilog.f -o uart_rx_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

sim_out=$(./obj_dir/uart_rx_sim)
status=$?
printf '%s\n' "$sim_out"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -qF '*** PASSED ***'; then
	exit 0
fi

echo "pass message not found in simulation output"
exit 1
